// ==== rs_pkg.sv ====
package rs_pkg;

  // Operand, tag and flag widths
  typedef logic [31:0] word_t;
  typedef logic [3:0]  tag_t;
  typedef logic [3:0]  nzcv_t;

  // Flag bit positions inside nzcv_t
  localparam int NZCV_N = 3;
  localparam int NZCV_Z = 2;
  localparam int NZCV_C = 1;
  localparam int NZCV_V = 0;

  // Condition codes tested by CSEL
  typedef enum logic [1:0] {
    EQ,
    NE,
    LT,
    GE
  } cond_e;

  typedef enum logic [2:0] {
    ADD,
    SUB,
    AND,
    ORR,
    EOR,
    LSL,
    LSR,
    CSEL
  } alu_op_e;

  // Load/store view of the opcode field
  typedef struct packed {
    logic       is_store;
    logic [1:0] rsvd;
  } mem_op_t;

  // One opcode word, read by whichever station holds it
  typedef union packed {
    alu_op_e alu;
    mem_op_t mem;
  } fu_op_u;

  typedef enum logic {
    FU_ALU,
    FU_LS
  } fu_kind_e;

  localparam int DEF_RS_DEPTH  = 4;
  localparam int DEF_MEM_WORDS = 16;

endpackage

// ==== rs_issue_if.sv ====
interface rs_issue_if;

  logic           start;
  rs_pkg::fu_op_u op;
  rs_pkg::word_t  val_a;
  rs_pkg::word_t  val_b;
  rs_pkg::tag_t   dst_tag;
  rs_pkg::nzcv_t  nzcv;
  rs_pkg::cond_e  cond;
  // Entry asks for its flags to be published with the result
  logic           set_nzcv;

  modport station (
    output start, op, val_a, val_b, dst_tag, nzcv, cond, set_nzcv
  );

  modport unit (
    input start, op, val_a, val_b, dst_tag, nzcv, cond, set_nzcv
  );

endinterface

// ==== rs_result_if.sv ====
interface rs_result_if;

  // One result per strobe
  logic          valid;
  rs_pkg::tag_t  tag;
  rs_pkg::word_t value;
  rs_pkg::nzcv_t nzcv;
  logic          set_nzcv;

  modport producer (
    output valid, tag, value, nzcv, set_nzcv
  );

  modport consumer (
    input valid, tag, value, nzcv, set_nzcv
  );

endinterface

// ==== reservation_station.sv ====
module reservation_station #(
  parameter int               RS_DEPTH     = rs_pkg::DEF_RS_DEPTH,
  parameter rs_pkg::fu_kind_e STATION_KIND = rs_pkg::FU_ALU
) (
  input  logic           in_clk,
  input  logic           rst_n,
  input  logic           flush,
  input  logic           dispatch_valid,
  input  rs_pkg::fu_op_u dispatch_op,
  input  logic           a_valid,
  input  rs_pkg::word_t  a_value,
  input  rs_pkg::tag_t   a_tag,
  input  logic           b_valid,
  input  rs_pkg::word_t  b_value,
  input  rs_pkg::tag_t   b_tag,
  input  logic           flags_used,
  input  logic           flags_valid,
  input  rs_pkg::nzcv_t  flags_value,
  input  rs_pkg::tag_t   flags_tag,
  input  logic           set_flags,
  input  rs_pkg::cond_e  cond,
  input  rs_pkg::tag_t   dst_tag,
  input  logic           stall,
  rs_result_if.consumer  cdb,
  rs_issue_if.station    issue,
  output logic           has_free,
  output logic           has_ready
);

  // Index width leaves room for the "none" sentinel at RS_DEPTH
  localparam int IDX_W = $clog2(RS_DEPTH + 1);
  localparam int SEL_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;
  localparam logic [IDX_W-1:0] NONE = IDX_W'(RS_DEPTH);

  logic [RS_DEPTH-1:0] e_valid;
  rs_pkg::fu_op_u      e_op     [RS_DEPTH];
  logic                a_rdy    [RS_DEPTH];
  rs_pkg::word_t       a_val    [RS_DEPTH];
  rs_pkg::tag_t        a_src    [RS_DEPTH];
  logic                b_rdy    [RS_DEPTH];
  rs_pkg::word_t       b_val    [RS_DEPTH];
  rs_pkg::tag_t        b_src    [RS_DEPTH];
  logic                f_used   [RS_DEPTH];
  logic                f_rdy    [RS_DEPTH];
  rs_pkg::nzcv_t       f_val    [RS_DEPTH];
  rs_pkg::tag_t        f_src    [RS_DEPTH];
  logic                e_setf   [RS_DEPTH];
  rs_pkg::cond_e       e_cond   [RS_DEPTH];
  rs_pkg::tag_t        e_dst    [RS_DEPTH];

  logic [RS_DEPTH-1:0] free_map;
  logic [RS_DEPTH-1:0] ready_map;
  logic [IDX_W-1:0]    free_idx;
  logic [IDX_W-1:0]    ready_idx;
  logic [SEL_W-1:0]    free_sel;
  logic [SEL_W-1:0]    ready_sel;
  logic                any_store;
  logic                start;
  logic                a_hit;
  logic                b_hit;
  logic                f_hit;

  // Lowest set bit wins, NONE when the map is empty
  function automatic logic [IDX_W-1:0] first_set(input logic [RS_DEPTH-1:0] map);
    logic [IDX_W-1:0] idx;
    idx = NONE;
    for (int i = RS_DEPTH - 1; i >= 0; i--) begin
      if (map[i]) begin
        idx = IDX_W'(i);
      end
    end
    return idx;
  endfunction

  always_comb begin
    any_store = 1'b0;
    for (int i = 0; i < RS_DEPTH; i++) begin
      any_store = any_store | (e_valid[i] & e_op[i].mem.is_store);
    end
    for (int i = 0; i < RS_DEPTH; i++) begin
      free_map[i]  = ~e_valid[i];
      ready_map[i] = e_valid[i] & a_rdy[i] & b_rdy[i] & (~f_used[i] | f_rdy[i]);
      // Loads wait until no store is left in the station
      if (STATION_KIND == rs_pkg::FU_LS && !e_op[i].mem.is_store && any_store) begin
        ready_map[i] = 1'b0;
      end
    end
  end

  assign free_idx  = first_set(free_map);
  assign ready_idx = first_set(ready_map);
  assign has_free  = (free_idx != NONE);
  assign has_ready = (ready_idx != NONE);
  assign free_sel  = has_free ? free_idx[SEL_W-1:0] : '0;
  assign ready_sel = has_ready ? ready_idx[SEL_W-1:0] : '0;
  assign start     = has_ready & ~stall;

  assign issue.start    = start;
  assign issue.op       = e_op[ready_sel];
  assign issue.val_a    = a_val[ready_sel];
  assign issue.val_b    = b_val[ready_sel];
  assign issue.dst_tag  = e_dst[ready_sel];
  assign issue.nzcv     = f_val[ready_sel];
  assign issue.cond     = e_cond[ready_sel];
  assign issue.set_nzcv = e_setf[ready_sel];

  // Same-cycle bypass from the CDB into a new entry
  assign a_hit = ~a_valid & cdb.valid & (cdb.tag == a_tag);
  assign b_hit = ~b_valid & cdb.valid & (cdb.tag == b_tag);
  assign f_hit = ~flags_valid & cdb.valid & cdb.set_nzcv & (cdb.tag == flags_tag);

  always_ff @(posedge in_clk or negedge rst_n) begin
    if (!rst_n) begin
      e_valid <= '0;
    end else if (flush) begin
      e_valid <= '0;
    end else begin
      if (start) begin
        e_valid[ready_sel] <= 1'b0;
      end
      if (dispatch_valid && has_free) begin
        e_valid[free_sel] <= 1'b1;
      end
    end
  end

  always_ff @(posedge in_clk) begin
    // Waiting entries snoop the broadcast
    for (int i = 0; i < RS_DEPTH; i++) begin
      if (e_valid[i] && cdb.valid) begin
        if (!a_rdy[i] && a_src[i] == cdb.tag) begin
          a_rdy[i] <= 1'b1;
          a_val[i] <= cdb.value;
        end
        if (!b_rdy[i] && b_src[i] == cdb.tag) begin
          b_rdy[i] <= 1'b1;
          b_val[i] <= cdb.value;
        end
        if (f_used[i] && !f_rdy[i] && cdb.set_nzcv && f_src[i] == cdb.tag) begin
          f_rdy[i] <= 1'b1;
          f_val[i] <= cdb.nzcv;
        end
      end
    end
    if (dispatch_valid && has_free) begin
      e_op[free_sel]   <= dispatch_op;
      a_rdy[free_sel]  <= a_valid | a_hit;
      a_val[free_sel]  <= a_valid ? a_value : cdb.value;
      a_src[free_sel]  <= a_tag;
      b_rdy[free_sel]  <= b_valid | b_hit;
      b_val[free_sel]  <= b_valid ? b_value : cdb.value;
      b_src[free_sel]  <= b_tag;
      f_used[free_sel] <= flags_used;
      f_rdy[free_sel]  <= flags_valid | f_hit;
      f_val[free_sel]  <= flags_valid ? flags_value : cdb.nzcv;
      f_src[free_sel]  <= flags_tag;
      e_setf[free_sel] <= set_flags;
      e_cond[free_sel] <= cond;
      e_dst[free_sel]  <= dst_tag;
    end
  end

endmodule

// ==== rs_cluster.sv ====
module rs_cluster #(
  parameter int RS_DEPTH = rs_pkg::DEF_RS_DEPTH
) (
  input  logic             in_clk,
  input  logic             rst_n,
  input  logic             flush,
  input  logic             dispatch_valid,
  input  rs_pkg::fu_kind_e dispatch_kind,
  input  rs_pkg::fu_op_u   dispatch_op,
  input  logic             a_valid,
  input  rs_pkg::word_t    a_value,
  input  rs_pkg::tag_t     a_tag,
  input  logic             b_valid,
  input  rs_pkg::word_t    b_value,
  input  rs_pkg::tag_t     b_tag,
  input  logic             flags_used,
  input  logic             flags_valid,
  input  rs_pkg::nzcv_t    flags_value,
  input  rs_pkg::tag_t     flags_tag,
  input  logic             set_flags,
  input  rs_pkg::cond_e    cond,
  input  rs_pkg::tag_t     dst_tag,
  rs_result_if.consumer    alu_res,
  rs_result_if.consumer    ls_res,
  rs_issue_if.station      alu_issue,
  rs_issue_if.station      ls_issue,
  output logic             alu_has_free,
  output logic             ls_has_free,
  output logic             cdb_valid,
  output rs_pkg::tag_t     cdb_tag,
  output rs_pkg::word_t    cdb_value,
  output rs_pkg::nzcv_t    cdb_nzcv,
  output logic             cdb_set_nzcv
);

  rs_result_if cdb ();

  logic alu_dispatch;
  logic ls_dispatch;
  logic ls_has_ready;
  logic ls_issued_q;
  logic alu_stall;

  assign alu_dispatch = dispatch_valid & (dispatch_kind == rs_pkg::FU_ALU);
  assign ls_dispatch  = dispatch_valid & (dispatch_kind == rs_pkg::FU_LS);

  // LS never stalls, so its ready flag is its issue strobe.
  // Holding the ALU off for two cycles keeps its result clear of the LS slot
  assign alu_stall = ls_has_ready | ls_issued_q;

  always_ff @(posedge in_clk or negedge rst_n) begin
    if (!rst_n) begin
      ls_issued_q <= 1'b0;
      cdb.valid   <= 1'b0;
    end else begin
      ls_issued_q <= ls_has_ready;
      cdb.valid   <= alu_res.valid | ls_res.valid;
    end
  end

  // Units never collide, LS takes the slot if they ever did
  always_ff @(posedge in_clk) begin
    if (ls_res.valid) begin
      cdb.tag      <= ls_res.tag;
      cdb.value    <= ls_res.value;
      cdb.nzcv     <= ls_res.nzcv;
      cdb.set_nzcv <= ls_res.set_nzcv;
    end else begin
      cdb.tag      <= alu_res.tag;
      cdb.value    <= alu_res.value;
      cdb.nzcv     <= alu_res.nzcv;
      cdb.set_nzcv <= alu_res.set_nzcv;
    end
  end

  assign cdb_valid    = cdb.valid;
  assign cdb_tag      = cdb.tag;
  assign cdb_value    = cdb.value;
  assign cdb_nzcv     = cdb.nzcv;
  assign cdb_set_nzcv = cdb.set_nzcv;

  reservation_station #(
    .RS_DEPTH    (RS_DEPTH),
    .STATION_KIND(rs_pkg::FU_ALU)
  ) u_alu_rs (
    .in_clk        (in_clk),
    .rst_n         (rst_n),
    .flush         (flush),
    .dispatch_valid(alu_dispatch),
    .dispatch_op   (dispatch_op),
    .a_valid       (a_valid),
    .a_value       (a_value),
    .a_tag         (a_tag),
    .b_valid       (b_valid),
    .b_value       (b_value),
    .b_tag         (b_tag),
    .flags_used    (flags_used),
    .flags_valid   (flags_valid),
    .flags_value   (flags_value),
    .flags_tag     (flags_tag),
    .set_flags     (set_flags),
    .cond          (cond),
    .dst_tag       (dst_tag),
    .stall         (alu_stall),
    .cdb           (cdb.consumer),
    .issue         (alu_issue),
    .has_free      (alu_has_free),
    .has_ready     ()
  );

  reservation_station #(
    .RS_DEPTH    (RS_DEPTH),
    .STATION_KIND(rs_pkg::FU_LS)
  ) u_ls_rs (
    .in_clk        (in_clk),
    .rst_n         (rst_n),
    .flush         (flush),
    .dispatch_valid(ls_dispatch),
    .dispatch_op   (dispatch_op),
    .a_valid       (a_valid),
    .a_value       (a_value),
    .a_tag         (a_tag),
    .b_valid       (b_valid),
    .b_value       (b_value),
    .b_tag         (b_tag),
    .flags_used    (flags_used),
    .flags_valid   (flags_valid),
    .flags_value   (flags_value),
    .flags_tag     (flags_tag),
    .set_flags     (set_flags),
    .cond          (cond),
    .dst_tag       (dst_tag),
    .stall         (1'b0),
    .cdb           (cdb.consumer),
    .issue         (ls_issue),
    .has_free      (ls_has_free),
    .has_ready     (ls_has_ready)
  );

endmodule

// ==== alu_unit.sv ====
module alu_unit (
  input logic          in_clk,
  input logic          rst_n,
  rs_issue_if.unit     issue,
  rs_result_if.producer res
);

  logic [32:0]   add_w;
  logic [32:0]   sub_w;
  logic          cond_ok;
  logic          carry;
  logic          ovf;
  rs_pkg::word_t result;
  rs_pkg::nzcv_t nzcv_d;

  assign add_w = {1'b0, issue.val_a} + {1'b0, issue.val_b};
  // Carry out of a + ~b + 1 means no borrow
  assign sub_w = {1'b0, issue.val_a} + {1'b0, ~issue.val_b} + 33'd1;

  always_comb begin
    case (issue.cond)
      rs_pkg::EQ: cond_ok = issue.nzcv[rs_pkg::NZCV_Z];
      rs_pkg::NE: cond_ok = ~issue.nzcv[rs_pkg::NZCV_Z];
      rs_pkg::LT: cond_ok = issue.nzcv[rs_pkg::NZCV_N] ^ issue.nzcv[rs_pkg::NZCV_V];
      default:    cond_ok = ~(issue.nzcv[rs_pkg::NZCV_N] ^ issue.nzcv[rs_pkg::NZCV_V]);
    endcase
  end

  always_comb begin
    carry = 1'b0;
    ovf   = 1'b0;
    case (issue.op.alu)
      rs_pkg::ADD: begin
        result = add_w[31:0];
        carry  = add_w[32];
        ovf    = (issue.val_a[31] == issue.val_b[31]) && (result[31] != issue.val_a[31]);
      end
      rs_pkg::SUB: begin
        result = sub_w[31:0];
        carry  = sub_w[32];
        ovf    = (issue.val_a[31] != issue.val_b[31]) && (result[31] != issue.val_a[31]);
      end
      rs_pkg::AND: result = issue.val_a & issue.val_b;
      rs_pkg::ORR: result = issue.val_a | issue.val_b;
      rs_pkg::EOR: result = issue.val_a ^ issue.val_b;
      rs_pkg::LSL: result = issue.val_a << issue.val_b[4:0];
      rs_pkg::LSR: result = issue.val_a >> issue.val_b[4:0];
      default:     result = cond_ok ? issue.val_a : issue.val_b;
    endcase
    nzcv_d = {result[31], (result == '0), carry, ovf};
  end

  always_ff @(posedge in_clk or negedge rst_n) begin
    if (!rst_n) begin
      res.valid <= 1'b0;
    end else begin
      res.valid <= issue.start;
    end
  end

  always_ff @(posedge in_clk) begin
    res.tag      <= issue.dst_tag;
    res.value    <= result;
    res.nzcv     <= nzcv_d;
    res.set_nzcv <= issue.set_nzcv;
  end

endmodule

// ==== ls_unit.sv ====
module ls_unit #(
  parameter int MEM_WORDS = rs_pkg::DEF_MEM_WORDS
) (
  input logic           in_clk,
  input logic           rst_n,
  rs_issue_if.unit      issue,
  rs_result_if.producer res
);

  localparam int ADDR_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

  rs_pkg::word_t     mem [MEM_WORDS];
  logic [ADDR_W-1:0] addr;
  logic              s1_valid;
  logic              s1_store;
  logic [ADDR_W-1:0] s1_addr;
  rs_pkg::tag_t      s1_tag;

  assign addr = ADDR_W'(issue.val_a % MEM_WORDS);

  // Stage 1, stores commit to memory here
  always_ff @(posedge in_clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      res.valid <= 1'b0;
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else begin
      s1_valid  <= issue.start;
      res.valid <= s1_valid;
      if (issue.start && issue.op.mem.is_store) begin
        mem[addr] <= issue.val_b;
      end
    end
  end

  // Stage 2 reads after any store from an earlier issue
  always_ff @(posedge in_clk) begin
    s1_store  <= issue.op.mem.is_store;
    s1_addr   <= addr;
    s1_tag    <= issue.dst_tag;
    res.tag   <= s1_tag;
    res.value <= s1_store ? '0 : mem[s1_addr];
  end

  // Memory ops never touch the flags
  assign res.nzcv     = '0;
  assign res.set_nzcv = 1'b0;

endmodule

// ==== ooo_exec_core.sv ====
module ooo_exec_core #(
  parameter int RS_DEPTH  = rs_pkg::DEF_RS_DEPTH,
  parameter int MEM_WORDS = rs_pkg::DEF_MEM_WORDS
) (
  input  logic          in_clk,
  input  logic          rst_n,
  input  logic          dispatch_valid,
  input  logic          dispatch_kind,
  input  logic [2:0]    dispatch_op,
  input  logic          a_valid,
  input  rs_pkg::word_t a_value,
  input  rs_pkg::tag_t  a_tag,
  input  logic          b_valid,
  input  rs_pkg::word_t b_value,
  input  rs_pkg::tag_t  b_tag,
  input  logic          flags_used,
  input  logic          flags_valid,
  input  rs_pkg::nzcv_t flags_value,
  input  rs_pkg::tag_t  flags_tag,
  input  logic          set_flags,
  input  logic [1:0]    cond,
  input  rs_pkg::tag_t  dst_tag,
  input  logic          flush,
  output logic          alu_has_free,
  output logic          ls_has_free,
  output logic          cdb_valid,
  output rs_pkg::tag_t  cdb_tag,
  output rs_pkg::word_t cdb_value,
  output rs_pkg::nzcv_t cdb_nzcv,
  output logic          cdb_set_nzcv
);

  rs_issue_if  alu_issue ();
  rs_issue_if  ls_issue ();
  rs_result_if alu_res ();
  rs_result_if ls_res ();

  rs_pkg::fu_op_u op_word;

  // Raw opcode bits become the shared two-view word
  assign op_word = dispatch_op;

  rs_cluster #(
    .RS_DEPTH(RS_DEPTH)
  ) u_rs_cluster (
    .in_clk        (in_clk),
    .rst_n         (rst_n),
    .flush         (flush),
    .dispatch_valid(dispatch_valid),
    .dispatch_kind (rs_pkg::fu_kind_e'(dispatch_kind)),
    .dispatch_op   (op_word),
    .a_valid       (a_valid),
    .a_value       (a_value),
    .a_tag         (a_tag),
    .b_valid       (b_valid),
    .b_value       (b_value),
    .b_tag         (b_tag),
    .flags_used    (flags_used),
    .flags_valid   (flags_valid),
    .flags_value   (flags_value),
    .flags_tag     (flags_tag),
    .set_flags     (set_flags),
    .cond          (rs_pkg::cond_e'(cond)),
    .dst_tag       (dst_tag),
    .alu_res       (alu_res.consumer),
    .ls_res        (ls_res.consumer),
    .alu_issue     (alu_issue.station),
    .ls_issue      (ls_issue.station),
    .alu_has_free  (alu_has_free),
    .ls_has_free   (ls_has_free),
    .cdb_valid     (cdb_valid),
    .cdb_tag       (cdb_tag),
    .cdb_value     (cdb_value),
    .cdb_nzcv      (cdb_nzcv),
    .cdb_set_nzcv  (cdb_set_nzcv)
  );

  alu_unit u_alu_unit (
    .in_clk(in_clk),
    .rst_n (rst_n),
    .issue (alu_issue.unit),
    .res   (alu_res.producer)
  );

  ls_unit #(
    .MEM_WORDS(MEM_WORDS)
  ) u_ls_unit (
    .in_clk(in_clk),
    .rst_n (rst_n),
    .issue (ls_issue.unit),
    .res   (ls_res.producer)
  );

endmodule

// ==== tb_ooo_exec_core.sv ====
module tb_ooo_exec_core;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RS_DEPTH  = rs_pkg::DEF_RS_DEPTH;
  localparam int MEM_WORDS = rs_pkg::DEF_MEM_WORDS;

  logic          in_clk = 1'b0;
  logic          rst_n;
  logic          dispatch_valid;
  logic          dispatch_kind;
  logic [2:0]    dispatch_op;
  logic          a_valid;
  rs_pkg::word_t a_value;
  rs_pkg::tag_t  a_tag;
  logic          b_valid;
  rs_pkg::word_t b_value;
  rs_pkg::tag_t  b_tag;
  logic          flags_used;
  logic          flags_valid;
  rs_pkg::nzcv_t flags_value;
  rs_pkg::tag_t  flags_tag;
  logic          set_flags;
  logic [1:0]    cond;
  rs_pkg::tag_t  dst_tag;
  logic          flush;
  logic          alu_has_free;
  logic          ls_has_free;
  logic          cdb_valid;
  rs_pkg::tag_t  cdb_tag;
  rs_pkg::word_t cdb_value;
  rs_pkg::nzcv_t cdb_nzcv;
  logic          cdb_set_nzcv;

  // ROB model, indexed by tag
  rs_pkg::word_t exp_val   [16];
  rs_pkg::nzcv_t exp_nzcv  [16];
  logic          exp_setf  [16];
  logic          chk_nzcv  [16];
  logic          chk_lat   [16];
  int            disp_edge [16];
  int            sent_cnt  [16] = '{default: 0};
  int            seen_cnt  [16] = '{default: 0};
  rs_pkg::word_t shadow    [MEM_WORDS];
  int            cyc = 0;
  int            n_sent = 0;
  integer        seed = 32'h88c7_8ac8;

  ooo_exec_core #(
    .RS_DEPTH (RS_DEPTH),
    .MEM_WORDS(MEM_WORDS)
  ) u_ooo_exec_core (
    .in_clk(in_clk), .rst_n(rst_n), .dispatch_valid(dispatch_valid),
    .dispatch_kind(dispatch_kind), .dispatch_op(dispatch_op),
    .a_valid(a_valid), .a_value(a_value), .a_tag(a_tag),
    .b_valid(b_valid), .b_value(b_value), .b_tag(b_tag),
    .flags_used(flags_used), .flags_valid(flags_valid), .flags_value(flags_value),
    .flags_tag(flags_tag), .set_flags(set_flags), .cond(cond), .dst_tag(dst_tag),
    .flush(flush), .alu_has_free(alu_has_free), .ls_has_free(ls_has_free),
    .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
    .cdb_nzcv(cdb_nzcv), .cdb_set_nzcv(cdb_set_nzcv)
  );

  always #5 in_clk = ~in_clk;

  always @(posedge in_clk) cyc <= cyc + 1;

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
    stop_run($sformatf("Mismatch at time %0t: %s got 0x%h expected 0x%h",
                       $time, name, got, exp));
  endtask

  // Reference ALU, flags as N Z C V
  function automatic void alu_ref(input rs_pkg::alu_op_e op, input rs_pkg::word_t a,
                                  input rs_pkg::word_t b, input rs_pkg::nzcv_t f,
                                  input rs_pkg::cond_e cd, output rs_pkg::word_t r,
                                  output rs_pkg::nzcv_t nz);
    logic        c;
    logic        v;
    logic        take;
    c = 1'b0;
    v = 1'b0;
    case (op)
      rs_pkg::ADD: begin
        r = a + b;
        // Unsigned wrap means a carry out
        c = (r < a);
        v = (a[31] == b[31]) && (r[31] != a[31]);
      end
      rs_pkg::SUB: begin
        r = a - b;
        c = (a >= b);
        v = (a[31] != b[31]) && (r[31] != a[31]);
      end
      rs_pkg::AND: r = a & b;
      rs_pkg::ORR: r = a | b;
      rs_pkg::EOR: r = a ^ b;
      rs_pkg::LSL: r = a << b[4:0];
      rs_pkg::LSR: r = a >> b[4:0];
      default: begin
        case (cd)
          rs_pkg::EQ: take = f[2];
          rs_pkg::NE: take = !f[2];
          rs_pkg::LT: take = (f[3] != f[0]);
          default:    take = (f[3] == f[0]);
        endcase
        r = take ? a : b;
      end
    endcase
    nz = {r[31], r == 32'd0, c, v};
  endfunction

  function automatic logic all_done();
    logic ok;
    ok = 1'b1;
    for (int i = 0; i < 16; i++) begin
      if (sent_cnt[i] != seen_cnt[i]) ok = 1'b0;
    end
    return ok;
  endfunction

  // Holds one dispatch for a single cycle, caller sits at a falling edge
  task automatic drive_pins(input logic kind, input logic [2:0] op, input logic av,
                            input rs_pkg::word_t a, input rs_pkg::tag_t at, input logic bv,
                            input rs_pkg::word_t b, input rs_pkg::tag_t bt, input logic fu,
                            input rs_pkg::tag_t ft, input logic sf, input logic [1:0] cd,
                            input rs_pkg::tag_t dt);
    dispatch_valid = 1'b1;
    dispatch_kind  = kind;
    dispatch_op    = op;
    a_valid        = av;
    a_value        = a;
    a_tag          = at;
    b_valid        = bv;
    b_value        = b;
    b_tag          = bt;
    flags_used     = fu;
    flags_valid    = !fu;
    flags_tag      = ft;
    set_flags      = sf;
    cond           = cd;
    dst_tag        = dt;
    n_sent++;
    @(negedge in_clk);
    dispatch_valid = 1'b0;
  endtask

  task automatic note(input rs_pkg::tag_t dt, input rs_pkg::word_t v, input rs_pkg::nzcv_t nz,
                      input logic sf, input logic cn, input logic lat);
    exp_val[dt]   = v;
    exp_nzcv[dt]  = nz;
    exp_setf[dt]  = sf;
    chk_nzcv[dt]  = cn;
    chk_lat[dt]   = lat;
    disp_edge[dt] = cyc + 1;
    sent_cnt[dt]++;
  endtask

  // Negative source means the operand is given as a value
  task automatic send_alu(input rs_pkg::alu_op_e op, input int a_src, input rs_pkg::word_t a_imm,
                          input int b_src, input rs_pkg::word_t b_imm, input int f_src,
                          input rs_pkg::cond_e cd, input logic sf, input rs_pkg::tag_t dt,
                          input logic lat);
    rs_pkg::word_t a;
    rs_pkg::word_t b;
    rs_pkg::word_t r;
    rs_pkg::nzcv_t f;
    rs_pkg::nzcv_t nz;
    a = (a_src >= 0) ? exp_val[4'(a_src)] : a_imm;
    b = (b_src >= 0) ? exp_val[4'(b_src)] : b_imm;
    f = (f_src >= 0) ? exp_nzcv[4'(f_src)] : 4'h0;
    alu_ref(op, a, b, f, cd, r, nz);
    assert (alu_has_free) else stop_run("ALU station has no free entry at dispatch");
    note(dt, r, nz, sf, op != rs_pkg::CSEL, lat);
    drive_pins(1'b0, op, a_src < 0, a_imm, 4'(a_src), b_src < 0, b_imm, 4'(b_src),
               f_src >= 0, 4'(f_src), sf, cd, dt);
  endtask

  task automatic send_mem(input logic store, input rs_pkg::word_t addr,
                          input rs_pkg::word_t data, input rs_pkg::tag_t dt);
    int idx;
    idx = int'(addr % MEM_WORDS);
    assert (ls_has_free) else stop_run("Load/store station has no free entry at dispatch");
    if (store) begin
      shadow[idx] = data;
      note(dt, '0, '0, 1'b0, 1'b0, 1'b0);
    end else begin
      note(dt, shadow[idx], '0, 1'b0, 1'b0, 1'b0);
    end
    drive_pins(1'b1, {store, 2'b00}, 1'b1, addr, '0, 1'b1, data, '0, 1'b0, '0, 1'b0, 2'b00, dt);
  endtask

  task automatic wait_tag(input rs_pkg::tag_t t);
    do @(negedge in_clk); while (!(cdb_valid && cdb_tag == t));
  endtask

  task automatic drain();
    while (!all_done()) @(negedge in_clk);
  endtask

  assert property (@(negedge in_clk) rst_n || (!cdb_valid && alu_has_free && ls_has_free))
    else stop_run("CDB or station free flags not in reset state while reset is held");

  assert property (@(negedge in_clk) disable iff (!rst_n) cdb_valid |-> !$isunknown(cdb_tag))
    else stop_run("CDB tag is unknown during a broadcast");

  always @(negedge in_clk) begin : cdb_monitor
    if (rst_n && cdb_valid) begin
      assert (seen_cnt[cdb_tag] < sent_cnt[cdb_tag])
        else stop_run($sformatf("CDB broadcast tag %0d that is not outstanding", cdb_tag));
      assert (cdb_value == exp_val[cdb_tag])
        else mismatch("cdb_value", cdb_value, exp_val[cdb_tag]);
      assert (cdb_set_nzcv == exp_setf[cdb_tag])
        else mismatch("cdb_set_nzcv", 32'(cdb_set_nzcv), 32'(exp_setf[cdb_tag]));
      if (chk_nzcv[cdb_tag]) begin
        assert (cdb_nzcv == exp_nzcv[cdb_tag])
          else mismatch("cdb_nzcv", 32'(cdb_nzcv), 32'(exp_nzcv[cdb_tag]));
      end
      // Entry after edge k, issue freed at k+1, CDB after k+2
      if (chk_lat[cdb_tag]) begin
        assert (cyc == disp_edge[cdb_tag] + 2)
          else mismatch("cdb latency", 32'(cyc - disp_edge[cdb_tag]), 32'd2);
      end
      seen_cnt[cdb_tag]++;
    end
  end

  initial begin : watchdog
    wait (cyc > 200 + 40 * n_sent);
    stop_run("Watchdog timeout, the DUT stopped making progress");
  end

  initial begin : stimulus
    rs_pkg::word_t x;
    rs_pkg::word_t y;
    rs_pkg::word_t addr;
    rs_pkg::word_t addr2;
    rst_n = 1'b0;
    flush = 1'b0;
    dispatch_valid = 1'b0;
    dispatch_kind = 1'b0;
    dispatch_op = '0;
    a_valid = 1'b0;
    a_value = '0;
    a_tag = '0;
    b_valid = 1'b0;
    b_value = '0;
    b_tag = '0;
    flags_used = 1'b0;
    flags_valid = 1'b0;
    flags_value = '0;
    flags_tag = '0;
    set_flags = 1'b0;
    cond = '0;
    dst_tag = '0;
    for (int i = 0; i < MEM_WORDS; i++) shadow[i] = '0;
    repeat (8) @(posedge in_clk);
    @(negedge in_clk);
    rst_n = 1'b1;
    @(negedge in_clk);

    // Independent ALU ops back to back, every op but CSEL
    for (int i = 0; i < 8; i++) begin
      x = $random(seed);
      y = $random(seed);
      send_alu(rs_pkg::alu_op_e'(3'(i % 7)), -1, x, -1, y, -1, rs_pkg::EQ, x[0], 4'(i), 1'b1);
    end
    drain();

    // Chain through the CDB, snoop and same-cycle bypass
    x = $random(seed);
    y = $random(seed);
    send_alu(rs_pkg::ADD, -1, x, -1, y, -1, rs_pkg::EQ, 1'b0, 4'd0, 1'b1);
    send_alu(rs_pkg::SUB, 0, '0, -1, y ^ x, -1, rs_pkg::EQ, 1'b1, 4'd1, 1'b0);
    wait_tag(4'd1);
    send_alu(rs_pkg::EOR, 1, '0, -1, y, -1, rs_pkg::EQ, 1'b0, 4'd2, 1'b0);
    send_alu(rs_pkg::LSL, 2, '0, -1, x, -1, rs_pkg::EQ, 1'b1, 4'd3, 1'b0);
    send_alu(rs_pkg::ORR, 3, '0, 3, '0, -1, rs_pkg::EQ, 1'b0, 4'd4, 1'b0);
    wait_tag(4'd4);
    send_alu(rs_pkg::ADD, -1, y, 4, '0, -1, rs_pkg::EQ, 1'b1, 4'd5, 1'b0);
    drain();

    // CSEL waiting on SUB flags
    x = $random(seed);
    y = $random(seed);
    send_alu(rs_pkg::SUB, -1, x, -1, y, -1, rs_pkg::EQ, 1'b1, 4'd6, 1'b1);
    send_alu(rs_pkg::CSEL, -1, y, -1, x, 6, rs_pkg::cond_e'(x[1:0]), 1'b0, 4'd7, 1'b0);
    send_alu(rs_pkg::SUB, -1, y, -1, y, -1, rs_pkg::EQ, 1'b1, 4'd8, 1'b0);
    send_alu(rs_pkg::CSEL, -1, x, -1, y, 8, rs_pkg::EQ, 1'b0, 4'd9, 1'b0);
    drain();

    // Stores and loads interleaved with ALU work
    addr = $random(seed);
    addr2 = addr + 32'd5;
    x = $random(seed);
    y = $random(seed);
    send_mem(1'b1, addr, x, 4'd0);
    send_alu(rs_pkg::ADD, -1, x, -1, y, -1, rs_pkg::EQ, 1'b1, 4'd1, 1'b0);
    send_mem(1'b0, addr, '0, 4'd2);
    send_alu(rs_pkg::AND, -1, y, -1, x, -1, rs_pkg::EQ, 1'b0, 4'd3, 1'b0);
    send_mem(1'b1, addr2, y, 4'd4);
    send_mem(1'b0, addr2, '0, 4'd5);
    send_mem(1'b0, addr, '0, 4'd6);
    send_alu(rs_pkg::LSR, -1, x, -1, y, -1, rs_pkg::EQ, 1'b1, 4'd7, 1'b0);
    drain();

    // Fill each station with entries that never resolve, then flush
    for (int k = 0; k < 2; k++) begin
      for (int i = 0; i < RS_DEPTH; i++) begin
        drive_pins(k[0], 3'b000, 1'b0, '0, 4'hf, 1'b1, '0, '0, 1'b0, '0, 1'b0, 2'b00, 4'(i));
      end
      assert (k == 0 ? !alu_has_free : !ls_has_free)
        else stop_run("Station still reports a free entry after being filled");
      x = $random(seed);
      flush = 1'b1;
      // Dispatch into the empty station is dropped by the flush
      drive_pins(!k[0], k == 1 ? 3'(rs_pkg::ADD) : 3'b100, 1'b1, x, '0, 1'b1, x, '0,
                 1'b0, '0, 1'b0, 2'b00, 4'(8 + k));
      flush = 1'b0;
      assert (alu_has_free && ls_has_free)
        else stop_run("Station has no free entry right after a flush");
    end
    repeat (12) @(negedge in_clk);
    send_alu(rs_pkg::ADD, -1, x, -1, 32'd1, -1, rs_pkg::EQ, 1'b1, 4'd13, 1'b1);
    drain();

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// ==== ooo_exec_core.f ====
rs_pkg.sv
rs_issue_if.sv
rs_result_if.sv
reservation_station.sv
rs_cluster.sv
alu_unit.sv
ls_unit.sv
ooo_exec_core.sv
tb_ooo_exec_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the ooo_exec_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
  --top-module tb_ooo_exec_core \
  -f ooo_exec_core.f \
  -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "CHECKS FAILED" "$LOG"; then
  echo "Simulation reported failure"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi
exit 0
